// File: Bender.yml
package:
  name: i2c_accel

sources:
  - design/i2c_pkg.sv
  - design/i2c_ctrl_decode.sv
  - design/i2c_scl_gen.sv
  - design/i2c_bit_engine.sv
  - design/i2c_read_capture.sv
  - design/i2c_accel_top.sv
  - target: test
    files:
      - test/i2c_target_model.sv
      - test/i2c_accel_chk.sv
      - test/tb_i2c_accel.sv

// File: design/i2c_accel_top.sv
`timescale 1ns/100ps

module i2c_accel_top #(
	parameter int unsigned BURST_LEN   = 9,
	parameter logic [6:0]  HW_DEV_ADDR = 7'h1D,
	parameter logic [7:0]  HW_REG_ADDR = 8'h08
) (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  i2c_pkg::ctrl_t            i_ctrl,
	input  logic [6:0]                i_dev_addr,
	input  logic [7:0]                i_reg_addr,
	input  logic [7:0]                i_w_data,
	input  logic                      i_drdy,
	input  logic                      i_sda,
	output logic                      o_scl_low,
	output logic                      o_sda_low,
	output i2c_pkg::status_t          o_status,
	output logic [BURST_LEN-1:0][7:0] o_rd_data
);
	import i2c_pkg::*;

	logic       go;
	i2c_cmd_t   cmd;
	logic       tick;
	logic       busy;
	logic [7:0] phase;
	rx_byte_t   rx;
	xfer_evt_t  evt;

	i2c_ctrl_decode #(
		.HW_DEV_ADDR(HW_DEV_ADDR),
		.HW_REG_ADDR(HW_REG_ADDR)
	) u_decode (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_ctrl    (i_ctrl),
		.i_dev_addr(i_dev_addr),
		.i_reg_addr(i_reg_addr),
		.i_w_data  (i_w_data),
		.i_drdy    (i_drdy),
		.i_busy    (busy),
		.o_go      (go),
		.o_cmd     (cmd)
	);

	i2c_scl_gen u_scl_gen (
		.i_clk  (i_clk),
		.i_rst_n(i_rst_n),
		.i_run  (busy),
		.i_rate (cmd.rate),
		.o_tick (tick)
	);

	i2c_bit_engine #(
		.BURST_LEN(BURST_LEN)
	) u_engine (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_go     (go),
		.i_cmd    (cmd),
		.i_tick   (tick),
		.i_sda    (i_sda),
		.o_scl_low(o_scl_low),
		.o_sda_low(o_sda_low),
		.o_busy   (busy),
		.o_phase  (phase),
		.o_rx     (rx),
		.o_evt    (evt)
	);

	i2c_read_capture #(
		.BURST_LEN(BURST_LEN)
	) u_capture (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_rx     (rx),
		.i_evt    (evt),
		.i_busy   (busy),
		.i_phase  (phase),
		.o_status (o_status),
		.o_rd_data(o_rd_data)
	);

endmodule

// File: design/i2c_bit_engine.sv
`timescale 1ns/100ps

module i2c_bit_engine #(
	parameter int unsigned BURST_LEN = 9
) (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_go,
	input  i2c_pkg::i2c_cmd_t  i_cmd,
	input  logic               i_tick,
	input  logic               i_sda,
	output logic               o_scl_low,
	output logic               o_sda_low,
	output logic               o_busy,
	output logic [7:0]         o_phase,
	output i2c_pkg::rx_byte_t  o_rx,
	output i2c_pkg::xfer_evt_t o_evt
);
	import i2c_pkg::*;

	phase_e           state;
	logic [1:0]       qtr;       // quarter of the current bit
	logic [2:0]       bit_cnt;
	logic [IDX_W-1:0] byte_cnt;
	logic [IDX_W-1:0] last_idx;
	logic [7:0]       sh;        // shared tx and rx shifter
	logic             rd_pass;   // second transaction of a register read
	logic             ack_n;
	logic             nack_seen;
	logic             last_byte;
	logic             clk_low;
	logic             rx_valid;
	logic [IDX_W-1:0] rx_idx;
	logic [7:0]       rx_data;

	assign last_idx  = i_cmd.is_burst ? IDX_W'(BURST_LEN - 1) : '0;
	assign last_byte = (byte_cnt == last_idx);
	assign clk_low   = (qtr == 2'd0) || (qtr == 2'd3);

	assign o_busy  = (state != PH_IDLE);
	assign o_phase = state;
	assign o_rx    = '{valid: rx_valid, index: rx_idx, data: rx_data};

	// line drive, scl high on quarters 1 and 2
	always_comb begin
		o_scl_low = 1'b0;
		o_sda_low = 1'b0;
		case (state)
			PH_START: begin
				o_scl_low = (qtr == 2'd3);
				o_sda_low = (qtr >= 2'd2); // sda falls while scl high
			end
			PH_STOP: begin
				o_scl_low = (qtr == 2'd0);
				o_sda_low = (qtr <= 2'd1); // sda rises while scl high
			end
			PH_RESTART: begin
				if (bit_cnt == 3'd1) begin // stop half
					o_scl_low = (qtr == 2'd0);
					o_sda_low = (qtr <= 2'd1);
				end else begin // start half
					o_scl_low = (qtr == 2'd3);
					o_sda_low = (qtr >= 2'd2);
				end
			end
			PH_ADDR, PH_REG, PH_WDATA: begin
				o_scl_low = clk_low;
				o_sda_low = ~sh[7]; // msb first
			end
			PH_MACK: begin
				o_scl_low = clk_low;
				o_sda_low = ~last_byte; // nack the final byte
			end
			PH_ADDR_ACK, PH_REG_ACK, PH_WDATA_ACK, PH_RDATA: o_scl_low = clk_low;
			default: ;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= PH_IDLE;
			qtr       <= 2'd0;
			bit_cnt   <= 3'd0;
			byte_cnt  <= '0;
			rd_pass   <= 1'b0;
			ack_n     <= 1'b1;
			nack_seen <= 1'b0;
			rx_valid  <= 1'b0;
			o_evt     <= '0;
		end else begin
			o_evt    <= '0;
			rx_valid <= 1'b0;
			if (state == PH_IDLE) begin
				qtr <= 2'd0;
				if (i_go) begin
					state     <= PH_START;
					bit_cnt   <= 3'd0;
					byte_cnt  <= '0;
					rd_pass   <= 1'b0;
					nack_seen <= 1'b0;
					o_evt.start <= 1'b1;
				end
			end else if (i_tick) begin
				qtr <= qtr + 2'd1;
				if (qtr == 2'd1) begin // end of first high quarter
					ack_n <= i_sda;
					if (state == PH_RDATA)
						sh <= {sh[6:0], i_sda};
				end
				if (qtr == 2'd3) begin // end of bit
					if (bit_cnt != 3'd0)
						bit_cnt <= bit_cnt - 3'd1;
					if (state inside {PH_ADDR, PH_REG, PH_WDATA})
						sh <= {sh[6:0], 1'b0};
					if (bit_cnt == 3'd0) begin
						case (state)
							PH_START: begin
								state   <= PH_ADDR;
								sh      <= {i_cmd.dev_addr, rd_pass};
								bit_cnt <= 3'd7;
							end
							PH_ADDR:  state <= PH_ADDR_ACK;
							PH_REG:   state <= PH_REG_ACK;
							PH_WDATA: state <= PH_WDATA_ACK;
							PH_ADDR_ACK: begin
								bit_cnt <= 3'd7;
								if (ack_n) begin
									state     <= PH_STOP;
									bit_cnt   <= 3'd0;
									nack_seen <= 1'b1;
								end else if (rd_pass) begin
									state <= PH_RDATA;
								end else begin
									state <= PH_REG;
									sh    <= i_cmd.reg_addr;
								end
							end
							PH_REG_ACK: begin
								if (ack_n) begin
									state     <= PH_STOP;
									nack_seen <= 1'b1;
								end else if (i_cmd.is_read) begin
									state   <= PH_RESTART;
									bit_cnt <= 3'd1; // stop bit then start bit
								end else begin
									state   <= PH_WDATA;
									sh      <= i_cmd.w_data;
									bit_cnt <= 3'd7;
								end
							end
							PH_WDATA_ACK: begin
								state     <= PH_STOP;
								nack_seen <= ack_n;
							end
							PH_RESTART: begin
								state   <= PH_ADDR;
								rd_pass <= 1'b1;
								sh      <= {i_cmd.dev_addr, 1'b1};
								bit_cnt <= 3'd7;
							end
							PH_RDATA: begin
								state    <= PH_MACK;
								rx_valid <= 1'b1;
								rx_idx   <= byte_cnt;
								rx_data  <= sh;
							end
							PH_MACK: begin
								if (last_byte) begin
									state <= PH_STOP;
								end else begin
									state    <= PH_RDATA;
									bit_cnt  <= 3'd7;
									byte_cnt <= byte_cnt + 1'b1;
								end
							end
							PH_STOP: begin
								state      <= PH_IDLE;
								o_evt.done <= 1'b1;
								o_evt.nack <= nack_seen;
							end
							default: state <= PH_IDLE;
						endcase
					end
				end
			end
		end
	end

endmodule

// File: design/i2c_ctrl_decode.sv
`timescale 1ns/100ps

module i2c_ctrl_decode #(
	parameter logic [6:0] HW_DEV_ADDR = 7'h1D,
	parameter logic [7:0] HW_REG_ADDR = 8'h08
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  i2c_pkg::ctrl_t    i_ctrl,
	input  logic [6:0]        i_dev_addr,
	input  logic [7:0]        i_reg_addr,
	input  logic [7:0]        i_w_data,
	input  logic              i_drdy,
	input  logic              i_busy,
	output logic              o_go,
	output i2c_pkg::i2c_cmd_t o_cmd
);
	import i2c_pkg::*;

	logic     en_q;
	logic     drdy_q;
	logic     trig;
	logic     launch;
	i2c_cmd_t next_cmd;

	// hw mode listens to drdy, every other mode to the enable bit
	assign trig = (i_ctrl.mode == MODE_HW_BURST) ? (i_drdy & ~drdy_q)
		: (i_ctrl.enable & ~en_q);
	assign launch = trig & ~i_busy & ~o_go; // triggers while busy are lost

	always_comb begin
		next_cmd.dev_addr = i_dev_addr;
		next_cmd.reg_addr = i_reg_addr;
		next_cmd.w_data   = i_w_data;
		next_cmd.is_read  = i_ctrl.rw;
		next_cmd.is_burst = 1'b0;
		case (i_ctrl.mode)
			MODE_CPU_SINGLE: next_cmd.is_burst = 1'b0;
			MODE_CPU_BURST:  next_cmd.is_burst = 1'b1;
			MODE_HW_BURST: begin
				next_cmd.dev_addr = HW_DEV_ADDR;
				next_cmd.reg_addr = HW_REG_ADDR;
				next_cmd.is_read  = 1'b1; // sensor data is always read
				next_cmd.is_burst = 1'b1;
			end
			default: next_cmd.is_burst = 1'b0; // reserved acts as single
		endcase
		case (i_ctrl.rate)
			RATE_195K, RATE_390K, RATE_781K, RATE_1562K: next_cmd.rate = i_ctrl.rate;
			default: next_cmd.rate = RATE_DEFAULT;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			en_q   <= 1'b0;
			drdy_q <= 1'b0;
			o_go   <= 1'b0;
		end else begin
			en_q   <= i_ctrl.enable;
			drdy_q <= i_drdy;
			o_go   <= launch;
		end
	end

	// held steady until the next go
	always_ff @(posedge i_clk) begin
		if (launch)
			o_cmd <= next_cmd;
	end

endmodule

// File: design/i2c_pkg.sv
package i2c_pkg;

	localparam int MAX_BURST = 16;
	localparam int IDX_W     = $clog2(MAX_BURST);

	// rate codes, scl period is 2^(code+1) system clocks
	localparam logic [2:0] RATE_195K    = 3'd7;
	localparam logic [2:0] RATE_390K    = 3'd6;
	localparam logic [2:0] RATE_781K    = 3'd5;
	localparam logic [2:0] RATE_1562K   = 3'd4;
	localparam logic [2:0] RATE_DEFAULT = RATE_390K;

	localparam logic [1:0] MODE_CPU_SINGLE = 2'd0;
	localparam logic [1:0] MODE_CPU_BURST  = 2'd1;
	localparam logic [1:0] MODE_HW_BURST   = 2'd2;

	typedef struct packed {
		logic [24:0] rsvd;
		logic [2:0]  rate;
		logic [1:0]  mode;
		logic        rw;     // 1 = register read
		logic        enable;
	} ctrl_t;

	typedef struct packed {
		logic [20:0] zero;
		logic [7:0]  phase;
		logic        nack;   // sticky until next start
		logic        finish;
		logic        ready;
	} status_t;

	typedef struct packed {
		logic [6:0] dev_addr;
		logic [7:0] reg_addr;
		logic [7:0] w_data;
		logic       is_read;
		logic       is_burst;
		logic [2:0] rate;    // always 4..7
	} i2c_cmd_t;

	typedef struct packed {
		logic             valid;
		logic [IDX_W-1:0] index;
		logic [7:0]       data;
	} rx_byte_t;

	typedef struct packed {
		logic start;
		logic done;
		logic nack;
	} xfer_evt_t;

	// engine state codes, reported in status.phase
	typedef enum logic [7:0] {
		PH_IDLE      = 8'd0,
		PH_START     = 8'd1,
		PH_ADDR      = 8'd2,
		PH_ADDR_ACK  = 8'd3,
		PH_REG       = 8'd4,
		PH_REG_ACK   = 8'd5,
		PH_WDATA     = 8'd6,
		PH_WDATA_ACK = 8'd7,
		PH_STOP      = 8'd8,
		PH_RESTART   = 8'd9,
		PH_RDATA     = 8'd10,
		PH_MACK      = 8'd11
	} phase_e;

endpackage

// File: design/i2c_read_capture.sv
`timescale 1ns/100ps

module i2c_read_capture #(
	parameter int unsigned BURST_LEN = 9
) (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  i2c_pkg::rx_byte_t         i_rx,
	input  i2c_pkg::xfer_evt_t        i_evt,
	input  logic                      i_busy,
	input  logic [7:0]                i_phase,
	output i2c_pkg::status_t          o_status,
	output logic [BURST_LEN-1:0][7:0] o_rd_data
);
	import i2c_pkg::*;

	logic finish_q;
	logic nack_q;

	// one slot per byte of the burst
	always_ff @(posedge i_clk) begin
		if (i_rx.valid && (i_rx.index < BURST_LEN))
			o_rd_data[i_rx.index] <= i_rx.data;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			finish_q <= 1'b0;
			nack_q   <= 1'b0;
		end else if (i_evt.start) begin
			finish_q <= 1'b0;
			nack_q   <= 1'b0;
		end else begin
			if (i_evt.done)
				finish_q <= 1'b1;
			if (i_evt.nack)
				nack_q <= 1'b1; // stays until the next transfer
		end
	end

	always_comb begin
		o_status        = '0;
		o_status.ready  = ~i_busy;
		o_status.finish = finish_q & ~i_busy; // old finish hidden once a new transfer runs
		o_status.nack   = nack_q;
		o_status.phase  = i_phase;
	end

endmodule

// File: design/i2c_scl_gen.sv
`timescale 1ns/100ps

module i2c_scl_gen (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_run,
	input  logic [2:0] i_rate,
	output logic       o_tick
);

	localparam int CNT_W = 6; // enough for rate 7, 64 clocks per quarter

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] term;
	logic [CNT_W:0]   span;

	// one quarter bit lasts 2^(rate-1) clocks
	assign span = (CNT_W+1)'(1) << (i_rate - 3'd1);
	assign term = CNT_W'(span - 1'b1);

	assign o_tick = i_run && (cnt == term);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt <= '0;
		end else if (!i_run) begin
			cnt <= '0; // realign to the start of a transfer
		end else if (cnt == term) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: sim.f
design/i2c_pkg.sv
design/i2c_ctrl_decode.sv
design/i2c_scl_gen.sv
design/i2c_bit_engine.sv
design/i2c_read_capture.sv
design/i2c_accel_top.sv
test/i2c_target_model.sv
test/i2c_accel_chk.sv
test/tb_i2c_accel.sv

// File: test/i2c_accel_chk.sv
`timescale 1ns/100ps

module i2c_accel_chk (
	input logic             i_clk,
	input logic             i_rst_n,
	input logic             i_scl_low,
	input logic             i_sda_low,
	input logic             i_sda,
	input i2c_pkg::status_t i_status
);
	import i2c_pkg::*;

	int err_cnt = 0;

	// data may only move while scl is low
	property sda_quiet_when_scl_high;
		@(posedge i_clk) disable iff (!i_rst_n)
		(!i_scl_low && $past(!i_scl_low) && (i_sda != $past(i_sda)))
			|-> (i_status.phase inside {PH_START, PH_STOP, PH_RESTART});
	endproperty

	property lines_free_when_idle;
		@(posedge i_clk) disable iff (!i_rst_n)
		i_status.ready |-> (!i_scl_low && !i_sda_low);
	endproperty

	property status_low_when_busy;
		@(posedge i_clk) disable iff (!i_rst_n)
		(i_status.phase != PH_IDLE) |-> (!i_status.ready && !i_status.finish);
	endproperty

	a_sda_quiet: assert property (sda_quiet_when_scl_high) else begin
		$error("sda changed while scl high outside start or stop");
		err_cnt++;
	end

	a_lines_free: assert property (lines_free_when_idle) else begin
		$error("bus line driven while engine idle");
		err_cnt++;
	end

	a_status_busy: assert property (status_low_when_busy) else begin
		$error("ready or finish high during a transfer");
		err_cnt++;
	end

endmodule

bind i2c_accel_top i2c_accel_chk u_chk (
	.i_clk    (i_clk),
	.i_rst_n  (i_rst_n),
	.i_scl_low(o_scl_low),
	.i_sda_low(o_sda_low),
	.i_sda    (i_sda),
	.i_status (o_status)
);

// File: test/i2c_target_model.sv
`timescale 1ns/100ps

module i2c_target_model #(
	parameter logic [6:0] DEV_ADDR = 7'h1D
) (
	input  logic i_scl,
	input  logic i_sda,
	output logic o_sda_low,
	output int   o_mack_cnt,
	output int   o_mnack_cnt
);
	typedef enum {
		T_IDLE, T_ADDR, T_ADDR_ACK, T_REG, T_REG_ACK,
		T_WDATA, T_WDATA_ACK, T_RDATA, T_MACK
	} tphase_e;

	logic [7:0] mem [256];
	tphase_e    ph;
	logic [7:0] sh;
	logic [7:0] ptr;      // register pointer
	logic [7:0] tx;
	logic       rd;
	logic       macked;
	int         bits;

	initial begin
		for (int a = 0; a < 256; a++)
			mem[a] = 8'(a) ^ 8'hA5;
		ph          = T_IDLE;
		o_sda_low   = 1'b0;
		o_mack_cnt  = 0;
		o_mnack_cnt = 0;
		bits        = 0;
		ptr         = '0;
		sh          = '0;
		rd          = 1'b0;
		macked      = 1'b0;
	end

	always @(negedge i_sda) if (i_scl) begin // start
		ph        = T_ADDR;
		bits      = 0;
		o_sda_low = 1'b0;
	end

	always @(posedge i_sda) if (i_scl) begin // stop
		ph        = T_IDLE;
		o_sda_low = 1'b0;
	end

	always @(posedge i_scl) begin
		if (ph inside {T_ADDR, T_REG, T_WDATA}) begin
			sh = {sh[6:0], i_sda};
			bits++;
		end else if (ph == T_MACK) begin
			macked = !i_sda;
			if (macked)
				o_mack_cnt++;
			else
				o_mnack_cnt++;
		end
	end

	// sda only moves here, while scl is low
	always @(negedge i_scl) begin
		case (ph)
			T_ADDR: if (bits == 8) begin
				if (sh[7:1] == DEV_ADDR) begin
					rd        = sh[0];
					o_sda_low = 1'b1;
					ph        = T_ADDR_ACK;
				end else begin
					ph = T_IDLE; // not ours, no ack
				end
			end
			T_ADDR_ACK: begin
				bits = 0;
				if (rd) begin
					tx        = mem[ptr];
					o_sda_low = !tx[7];
					ph        = T_RDATA;
				end else begin
					o_sda_low = 1'b0;
					ph        = T_REG;
				end
			end
			T_REG: if (bits == 8) begin
				ptr       = sh;
				o_sda_low = 1'b1;
				ph        = T_REG_ACK;
			end
			T_WDATA: if (bits == 8) begin
				mem[ptr]  = sh;
				ptr       = ptr + 8'd1;
				o_sda_low = 1'b1;
				ph        = T_WDATA_ACK;
			end
			T_REG_ACK, T_WDATA_ACK: begin
				o_sda_low = 1'b0;
				bits      = 0;
				ph        = T_WDATA;
			end
			T_RDATA: begin
				bits++;
				if (bits == 8) begin
					o_sda_low = 1'b0; // let master ack
					ph        = T_MACK;
				end else begin
					o_sda_low = !tx[7-bits];
				end
			end
			T_MACK: begin
				ptr = ptr + 8'd1;
				if (macked) begin
					tx        = mem[ptr];
					o_sda_low = !tx[7];
					bits      = 0;
					ph        = T_RDATA;
				end else begin
					o_sda_low = 1'b0;
					ph        = T_IDLE;
				end
			end
			default: ;
		endcase
	end

endmodule

// File: test/tb_i2c_accel.sv
`timescale 1ns/100ps

module tb_i2c_accel;
	import i2c_pkg::*;

	localparam int BURST = 9;
	localparam int TMO   = 100000; // cycles per wait

	logic                  clk = 1'b0;
	logic                  rst_n = 1'b0;
	ctrl_t                 ctrl = '0;
	logic [6:0]            dev_addr = '0;
	logic [7:0]            reg_addr = '0;
	logic [7:0]            w_data = '0;
	logic                  drdy = 1'b0;
	logic                  scl_low;
	logic                  sda_low;
	logic                  tgt_sda_low;
	wire                   scl = !scl_low;
	wire                   sda = !(sda_low | tgt_sda_low); // open drain
	status_t               status;
	logic [BURST-1:0][7:0] rd_data;
	logic [31:0]           seed = 32'd34123;
	logic [2:0]            rates [5] = '{3'd4, 3'd5, 3'd6, 3'd7, 3'd0};
	logic [7:0]            ra;
	int                    cnt_a;
	int                    cnt_b;
	int                    period;
	int                    exp_p;
	int                    mack_cnt;
	int                    mnack_cnt;
	int                    scl_rise = 0;

	always #50 clk = ~clk;

	always @(posedge scl)
		scl_rise++;

	i2c_accel_top #(.BURST_LEN(BURST), .HW_DEV_ADDR(7'h1D), .HW_REG_ADDR(8'h08)) UUT (
		.i_clk(clk), .i_rst_n(rst_n), .i_ctrl(ctrl), .i_dev_addr(dev_addr),
		.i_reg_addr(reg_addr), .i_w_data(w_data), .i_drdy(drdy), .i_sda(sda),
		.o_scl_low(scl_low), .o_sda_low(sda_low), .o_status(status), .o_rd_data(rd_data)
	);

	i2c_target_model #(.DEV_ADDR(7'h1D)) u_tgt (
		.i_scl(scl), .i_sda(sda), .o_sda_low(tgt_sda_low), .o_mack_cnt(mack_cnt),
		.o_mnack_cnt(mnack_cnt)
	);

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic fail_value(input string msg);
		stop_run($sformatf("FAILED at %0t ns: %s", $time, msg));
	endtask

	function automatic logic [7:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[23:16];
	endfunction

	// register contents after the write test
	function automatic logic [7:0] reg_value(input logic [7:0] a);
		return (a == 8'h12) ? 8'h3C : (a ^ 8'hA5);
	endfunction

	task automatic wait_busy();
		int n;
		n = 0;
		while (status.ready) begin
			@(negedge clk);
			n++;
			if (n > TMO)
				stop_run("timeout: transfer never started");
		end
	endtask

	task automatic wait_finish();
		int n;
		n = 0;
		while (!status.finish) begin
			@(negedge clk);
			n++;
			if (n > TMO)
				stop_run("timeout: transfer never finished");
		end
	endtask

	task automatic wait_phase(input logic [7:0] p);
		int n;
		n = 0;
		while (status.phase != p) begin
			@(negedge clk);
			n++;
			if (n > TMO)
				stop_run("timeout: engine never reached the expected phase");
		end
	endtask

	// cycles between two scl rising edges
	task automatic measure_scl(output int p);
		int  n;
		logic prev;
		for (int e = 0; e < 2; e++) begin
			n    = 0;
			prev = scl;
			@(negedge clk);
			while (!( !prev && scl)) begin
				prev = scl;
				@(negedge clk);
				n++;
				if (n > TMO)
					stop_run("timeout: no rising edge on scl");
			end
			p = n + 1;
		end
	endtask

	task automatic launch_cpu(input logic [1:0] mode, input logic rw, input logic [2:0] rate,
		input logic [6:0] dev, input logic [7:0] ra_in, input logic [7:0] wd);
		@(negedge clk);
		dev_addr  = dev;
		reg_addr  = ra_in;
		w_data    = wd;
		ctrl      = '0;
		ctrl.mode = mode;
		ctrl.rw   = rw;
		ctrl.rate = rate;
		@(negedge clk);
		ctrl.enable = 1'b1;
		wait_busy();
	endtask

	task automatic end_xfer();
		wait_finish();
		@(negedge clk);
		ctrl.enable = 1'b0;
	endtask

	task automatic check_bytes(input logic [7:0] base, input int n);
		for (int k = 0; k < n; k++)
			assert (rd_data[k] == reg_value(8'(base + k)))
			else fail_value($sformatf("byte %0d is %h, expected %h", k, rd_data[k],
				reg_value(8'(base + k))));
	endtask

	always @(negedge clk)
		if (UUT.u_chk.err_cnt != 0)
			stop_run("bus protocol assertion failed");

	initial begin
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		assert (!scl_low && !sda_low && status.ready && !status.finish && !status.nack)
		else fail_value("bad state after reset");

		launch_cpu(MODE_CPU_SINGLE, 1'b0, RATE_1562K, 7'h1D, 8'h12, 8'h3C);
		end_xfer();
		assert (u_tgt.mem[8'h12] == 8'h3C) else fail_value("register 12 not written");

		launch_cpu(MODE_CPU_SINGLE, 1'b1, RATE_1562K, 7'h1D, 8'h20, 8'h00);
		end_xfer();
		check_bytes(8'h20, 1);

		cnt_a = mack_cnt;
		cnt_b = mnack_cnt;
		@(negedge clk);
		ctrl      = '0;
		ctrl.mode = MODE_HW_BURST;
		ctrl.rate = RATE_1562K;
		drdy      = 1'b1;
		@(negedge clk);
		drdy = 1'b0;
		wait_busy();
		wait_finish();
		check_bytes(8'h08, BURST);
		assert ((mack_cnt - cnt_a == BURST - 1) && (mnack_cnt - cnt_b == 1))
		else fail_value("wrong master ack pattern in hardware burst");

		cnt_a = scl_rise;
		launch_cpu(MODE_CPU_SINGLE, 1'b0, RATE_1562K, 7'h22, 8'h30, 8'h55);
		end_xfer();
		assert (status.nack && status.finish) else fail_value("address nack not flagged");
		// 8 address bits, the ack bit and the stop
		assert (scl_rise - cnt_a == 10)
		else fail_value($sformatf("%0d scl pulses after address nack, expected 10",
			scl_rise - cnt_a));
		assert (scl && sda && !scl_low && !sda_low) else fail_value("bus not idle after nack");

		foreach (rates[i]) begin
			ra = lcg_next();
			launch_cpu(MODE_CPU_BURST, 1'b1, rates[i], 7'h1D, ra, 8'h00);
			wait_phase(PH_RDATA);
			measure_scl(period);
			exp_p = (rates[i] < 3'd4) ? 128 : (1 << (rates[i] + 1));
			assert (period == exp_p)
			else fail_value($sformatf("rate %0d scl period %0d, expected %0d",
				rates[i], period, exp_p));
			end_xfer();
			check_bytes(ra, BURST);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule
